/* hdl/rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // ====================================================================
    // opcodes and function codes
    // ====================================================================

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_br     = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3_t;

    // funct7 value that selects SUB and SRA.
    localparam logic [6:0] funct7_alt = 7'b0100000;

    localparam rv32i_word ebreak_instr = 32'h0010_0073;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

    // the encoding matches the branch funct3 field.
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_ops;

    // ====================================================================
    // instruction formats
    // ====================================================================

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } uj_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        sb_fmt_t sb;
        uj_fmt_t uj;
    } instr_u;

endpackage

/* hdl/pipeline_pkg.sv */
package pipeline_pkg;

    import rv32i_pkg::*;

    typedef enum logic {
        rs1_out,
        pc_out
    } alumux1_sel_t;

    typedef enum logic [1:0] {
        i_imm,
        u_imm,
        j_imm,
        rs2_out
    } alumux2_sel_t;

    typedef enum logic {
        alu_out,
        pc_plus4
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
        logic      valid;
    } if_id_t;

    typedef struct packed {
        rv32i_word       pc;
        rv32i_word       rs1_val;
        rv32i_word       rs2_val;
        rv32i_word       imm;
        rv32i_reg        rs1;
        rv32i_reg        rs2;
        rv32i_reg        rd;
        alu_ops          aluop;
        cmp_ops          cmpop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        logic            is_branch;
        logic            is_jump;
        logic            load_regfile;
        regfilemux_sel_t regfilemux_sel;
        logic            valid;
    } id_ex_t;

    typedef struct packed {
        rv32i_reg  rd;
        rv32i_word result;
        logic      load_regfile;
        logic      valid;
    } ex_wb_t;

    // addi x0, x0, 0.
    localparam rv32i_word nop_instr = 32'h0000_0013;

    localparam int drain_cycles = 2;

endpackage

/* hdl/pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl
    import pipeline_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic ebreak_seen,
    input  logic redirect,
    output logic fetch_en,
    output logic running,
    output logic halted
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain,
        st_halted
    } state_t;

    state_t     state;
    logic [1:0] drain_cnt;
    logic       stop;

    // an EBREAK behind a taken branch is about to be squashed.
    assign stop = ebreak_seen && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            drain_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (stop) begin
                        state     <= st_drain;
                        drain_cnt <= 2'(drain_cycles);
                    end
                end
                st_drain: begin
                    if (drain_cnt == 2'd1) begin
                        state <= st_halted;
                    end else begin
                        drain_cnt <= drain_cnt - 2'd1;
                    end
                end
                default: begin
                    state <= st_halted;
                end
            endcase
        end
    end

    assign fetch_en = (state == st_run) && !stop;
    assign running  = (state == st_run) || (state == st_drain);
    assign halted   = (state == st_halted);

endmodule

/* hdl/perf_counter.sv */
`timescale 1ns/1ps

module perf_counter
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      running,
    input  logic      retire,
    output rv32i_word cycle_count,
    output rv32i_word retired_count
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count   <= '0;
            retired_count <= '0;
        end else begin
            if (running) begin
                cycle_count <= cycle_count + 32'd1;
            end
            if (retire) begin
                retired_count <= retired_count + 32'd1;
            end
        end
    end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_en,
    input  logic      redirect,
    input  rv32i_word redirect_pc,
    output rv32i_word pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (fetch_en) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import rv32i_pkg::*, pipeline_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  if_id_t if_id,
    input  ex_wb_t wb,
    output id_ex_t id_ex_next,
    output logic   ebreak_seen
);

    instr_u      ir;
    rv32i_opcode opcode;
    rv32i_word   imm_i;
    rv32i_word   imm_b;
    rv32i_word   imm_u;
    rv32i_word   imm_j;
    rv32i_reg    rs1_idx;
    rv32i_word   rs1_val;
    rv32i_word   rs2_val;
    logic        rf_we;
    logic        known;
    logic        writes;
    rv32i_word   regs [32];

    function automatic alu_ops arith_op(logic [2:0] funct3, logic alt);
        case (arith_funct3_t'(funct3))
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign ir     = if_id.instr;
    assign opcode = rv32i_opcode'(ir.r.opcode);

    assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign imm_b = {{20{ir.sb.imm_hi[6]}}, ir.sb.imm_lo[0], ir.sb.imm_hi[5:0],
                    ir.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {ir.uj.imm, 12'b0};
    assign imm_j = {{12{ir.uj.imm[19]}}, ir.uj.imm[7:0], ir.uj.imm[8],
                    ir.uj.imm[18:9], 1'b0};

    assign ebreak_seen = if_id.valid && (opcode == op_system) && (if_id.instr == ebreak_instr);

    // ====================================================================
    // register file
    // ====================================================================

    // LUI reads x0 so that the ALU sees zero plus the immediate.
    assign rs1_idx = (opcode == op_lui) ? '0 : ir.r.rs1;
    assign rf_we   = wb.load_regfile && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // a write in the same cycle is passed straight to the read port.
    assign rs1_val = (rf_we && wb.rd == rs1_idx) ? wb.result : regs[rs1_idx];
    assign rs2_val = (rf_we && wb.rd == ir.r.rs2) ? wb.result : regs[ir.r.rs2];

    // ====================================================================
    // control
    // ====================================================================

    always_comb begin
        id_ex_next                = '0;
        id_ex_next.pc             = if_id.pc;
        id_ex_next.rs1_val        = rs1_val;
        id_ex_next.rs2_val        = rs2_val;
        id_ex_next.imm            = imm_i;
        id_ex_next.rs1            = rs1_idx;
        id_ex_next.rs2            = ir.r.rs2;
        id_ex_next.rd             = ir.r.rd;
        id_ex_next.aluop          = alu_add;
        id_ex_next.cmpop          = beq;
        id_ex_next.alumux1_sel    = rs1_out;
        id_ex_next.alumux2_sel    = i_imm;
        id_ex_next.regfilemux_sel = alu_out;
        known                     = 1'b1;
        writes                    = 1'b1;

        case (opcode)
            op_lui: begin
                id_ex_next.imm         = imm_u;
                id_ex_next.alumux2_sel = u_imm;
            end
            op_auipc: begin
                id_ex_next.imm         = imm_u;
                id_ex_next.alumux1_sel = pc_out;
                id_ex_next.alumux2_sel = u_imm;
            end
            op_jal: begin
                id_ex_next.imm            = imm_j;
                id_ex_next.alumux1_sel    = pc_out;
                id_ex_next.alumux2_sel    = j_imm;
                id_ex_next.is_jump        = 1'b1;
                id_ex_next.regfilemux_sel = pc_plus4;
            end
            op_br: begin
                // the ALU forms the target while the comparator decides.
                id_ex_next.imm         = imm_b;
                id_ex_next.alumux1_sel = pc_out;
                id_ex_next.cmpop       = cmp_ops'(ir.sb.funct3);
                id_ex_next.is_branch   = 1'b1;
                writes                 = 1'b0;
            end
            op_imm: begin
                id_ex_next.aluop = arith_op(ir.i.funct3,
                    (ir.i.funct3 == f3_sr) && (ir.r.funct7 == funct7_alt));
            end
            op_reg: begin
                id_ex_next.aluop       = arith_op(ir.r.funct3, ir.r.funct7 == funct7_alt);
                id_ex_next.alumux2_sel = rs2_out;
            end
            default: begin
                // EBREAK and anything unsupported leave decode as a bubble.
                known  = 1'b0;
                writes = 1'b0;
            end
        endcase

        id_ex_next.valid        = if_id.valid && known;
        id_ex_next.load_regfile = id_ex_next.valid && writes && (ir.r.rd != '0);
    end

endmodule

/* hdl/stage_regs.sv */
`timescale 1ns/1ps

module stage_regs
    import rv32i_pkg::*, pipeline_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_en,
    input  logic   redirect,
    input  if_id_t if_next,
    input  id_ex_t id_ex_next,
    input  ex_wb_t ex_wb_next,
    output if_id_t if_id,
    output id_ex_t id_ex,
    output ex_wb_t ex_wb
);

    function automatic if_id_t if_id_bubble();
        if_id_t b;
        b       = '0;
        b.instr = nop_instr;
        return b;
    endfunction

    function automatic id_ex_t id_ex_bubble();
        id_ex_t b;
        b                = '0;
        b.aluop          = alu_add;
        b.cmpop          = beq;
        b.alumux1_sel    = rs1_out;
        b.alumux2_sel    = i_imm;
        b.regfilemux_sel = alu_out;
        return b;
    endfunction

    // a redirect squashes the two instructions behind the branch.
    always_ff @(posedge clk) begin
        if (rst || redirect || !fetch_en) begin
            if_id <= if_id_bubble();
        end else begin
            if_id <= if_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            id_ex <= id_ex_bubble();
        end else begin
            id_ex <= id_ex_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_wb_next;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import rv32i_pkg::*, pipeline_pkg::*;
(
    input  id_ex_t    id_ex,
    input  ex_wb_t    ex_wb,
    output ex_wb_t    ex_wb_next,
    output logic      redirect,
    output rv32i_word redirect_pc
);

    logic      fwd_ok;
    rv32i_word rs1_fwd;
    rv32i_word rs2_fwd;
    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_result;
    rv32i_word wb_result;
    logic      cmp_true;

    // the instruction in writeback is the only one not yet in the register file.
    assign fwd_ok  = ex_wb.valid && ex_wb.load_regfile;
    assign rs1_fwd = (fwd_ok && id_ex.rs1 != '0 && ex_wb.rd == id_ex.rs1) ?
                     ex_wb.result : id_ex.rs1_val;
    assign rs2_fwd = (fwd_ok && id_ex.rs2 != '0 && ex_wb.rd == id_ex.rs2) ?
                     ex_wb.result : id_ex.rs2_val;

    assign alu_a = (id_ex.alumux1_sel == pc_out) ? id_ex.pc : rs1_fwd;

    always_comb begin
        case (id_ex.alumux2_sel)
            i_imm, u_imm, j_imm: alu_b = id_ex.imm;
            default:             alu_b = rs2_fwd;
        endcase
    end

    // ====================================================================
    // ALU and branch comparator
    // ====================================================================

    always_comb begin
        case (id_ex.aluop)
            alu_add:  alu_result = alu_a + alu_b;
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << alu_b[4:0];
            alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> alu_b[4:0];
            alu_sra:  alu_result = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
            alu_or:   alu_result = alu_a | alu_b;
            alu_and:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (id_ex.cmpop)
            beq:     cmp_true = (rs1_fwd == rs2_fwd);
            bne:     cmp_true = (rs1_fwd != rs2_fwd);
            blt:     cmp_true = ($signed(rs1_fwd) < $signed(rs2_fwd));
            bge:     cmp_true = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            bltu:    cmp_true = (rs1_fwd < rs2_fwd);
            bgeu:    cmp_true = (rs1_fwd >= rs2_fwd);
            default: cmp_true = 1'b0;
        endcase
    end

    // branches and JAL both take their target from the ALU.
    assign redirect    = id_ex.valid && (id_ex.is_jump || (id_ex.is_branch && cmp_true));
    assign redirect_pc = alu_result;

    assign wb_result = (id_ex.regfilemux_sel == pc_plus4) ? id_ex.pc + 32'd4 : alu_result;

    assign ex_wb_next = '{rd:           id_ex.rd,
                          result:       wb_result,
                          load_regfile: id_ex.load_regfile,
                          valid:        id_ex.valid};

endmodule

/* hdl/rv32i_core_top.sv */
`timescale 1ns/1ps

module rv32i_core_top
    import rv32i_pkg::*, pipeline_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output rv32i_word imem_addr,
    input  rv32i_word imem_rdata,
    output logic      wb_valid,
    output rv32i_reg  wb_rd,
    output rv32i_word wb_data,
    output logic      halted,
    output rv32i_word cycle_count,
    output rv32i_word retired_count
);

    logic      fetch_en;
    logic      running;
    logic      redirect;
    logic      ebreak_seen;
    rv32i_word pc;
    rv32i_word redirect_pc;
    if_id_t    if_next;
    if_id_t    if_id;
    id_ex_t    id_ex_next;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb_next;
    ex_wb_t    ex_wb;

    assign imem_addr = pc;
    assign if_next   = '{pc: pc, instr: imem_rdata, valid: 1'b1};

    // load_regfile is only set for valid writes to a nonzero register.
    assign wb_valid  = ex_wb.load_regfile;
    assign wb_rd     = ex_wb.rd;
    assign wb_data   = ex_wb.result;

    pipe_ctrl u_ctrl (.*);

    perf_counter u_perf (.*, .retire(ex_wb.valid));

    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*, .wb(ex_wb));

    stage_regs u_regs (.*);

    execute_stage u_exec (.*);

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // half of the 10 ns period.
    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

/* verif/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int wb_timeout   = 40;
    localparam int halt_timeout = 40;
    localparam int quiet_cycles = 20;

    localparam logic [6:0]  opc_reg     = 7'b0110011;
    localparam logic [6:0]  opc_imm     = 7'b0010011;
    localparam logic [6:0]  opc_lui     = 7'b0110111;
    localparam logic [6:0]  opc_auipc   = 7'b0010111;
    localparam logic [6:0]  opc_br      = 7'b1100011;
    localparam logic [6:0]  opc_jal     = 7'b1101111;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // instructions 0 to 28 reach writeback except the four squashed ones.
    localparam logic [31:0] exp_retired = 32'd25;
    // 31 cycles in run up to the EBREAK in decode, then two cycles of drain.
    localparam logic [31:0] exp_cycles  = 32'd33;

    logic        clk;
    logic        rst;
    logic        start;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        halted;
    logic [31:0] cycle_count;
    logic [31:0] retired_count;

    logic [31:0] rom [64];
    int          prog_len;
    int          exp_test [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          test_errors [];
    int          checks;
    int          errors;
    bit          timed_out;

    tb_clock u_clock (.clk(clk));

    rv32i_core_top UUT (.*);

    // the ROM answers in the same cycle; past the program it returns EBREAK.
    always_comb begin
        if (imem_addr[31:2] < 30'(prog_len)) begin
            imem_rdata = rom[imem_addr[7:2]];
        end else begin
            imem_rdata = ebreak_word;
        end
    end

    // ======================================================================
    // instruction encoders
    // ======================================================================

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_reg};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc_imm};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] opc, int imm, int rd);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] b_type(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opc_br};
    endfunction

    function automatic logic [31:0] j_type(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
    endfunction

    task automatic add_instr(logic [31:0] word);
        rom[6'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic add_writeback(int test, int rd, logic [31:0] data);
        exp_test.push_back(test);
        exp_rd.push_back(rd[4:0]);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        add_instr(i_type(5, 0, 0, 1));              // addi x1, x0, 5
        add_instr(i_type(-3, 1, 0, 2));             // addi x2, x1, -3
        add_instr(r_type(0, 2, 1, 0, 3));           // add  x3, x1, x2
        add_instr(r_type(32, 3, 2, 0, 4));          // sub  x4, x2, x3
        add_instr(r_type(0, 2, 3, 1, 5));           // sll  x5, x3, x2
        add_instr(r_type(0, 1, 4, 2, 6));           // slt  x6, x4, x1
        add_instr(r_type(0, 1, 4, 3, 7));           // sltu x7, x4, x1
        add_instr(r_type(0, 3, 5, 4, 8));           // xor  x8, x5, x3
        add_instr(r_type(0, 2, 4, 5, 9));           // srl  x9, x4, x2
        add_instr(r_type(32, 2, 4, 5, 10));         // sra  x10, x4, x2
        add_instr(r_type(0, 6, 8, 6, 11));          // or   x11, x8, x6
        add_instr(r_type(0, 5, 8, 7, 12));          // and  x12, x8, x5
        add_instr(i_type(4, 1, 1, 13));             // slli x13, x1, 4
        add_instr(i_type('h401, 4, 5, 14));         // srai x14, x4, 1
        add_instr(i_type('hff, 13, 4, 15));         // xori x15, x13, 0xff
        add_instr(i_type(6, 1, 3, 16));             // sltiu x16, x1, 6
        add_instr(b_type(12, 6, 16, 0));            // beq  x16, x6, +12
        add_instr(i_type(1, 0, 0, 20));
        add_instr(i_type(2, 0, 0, 21));
        add_instr(b_type(8, 16, 6, 1));             // bne  x6, x16, +8
        add_instr(i_type(9, 16, 0, 17));            // addi x17, x16, 9
        add_instr(j_type(12, 18));                  // jal  x18, +12
        add_instr(i_type(3, 0, 0, 22));
        add_instr(i_type(4, 0, 0, 23));
        add_instr(u_type(opc_lui, 'h12345, 19));    // lui   x19, 0x12345
        add_instr(u_type(opc_auipc, 1, 24));        // auipc x24, 0x1 at pc 0x64
        add_instr(i_type(1, 19, 0, 0));             // addi  x0, x19, 1
        add_instr(i_type('h678, 19, 0, 25));        // addi  x25, x19, 0x678
        add_instr(r_type(0, 0, 24, 0, 26));         // add   x26, x24, x0
        add_instr(ebreak_word);
        add_instr(i_type(7, 0, 0, 27));

        // expected writes in program order, worked out from the ISA.
        add_writeback(2, 1, 32'h0000_0005);
        add_writeback(2, 2, 32'h0000_0002);
        add_writeback(2, 3, 32'h0000_0007);
        add_writeback(2, 4, 32'hffff_fffb);
        add_writeback(2, 5, 32'h0000_001c);
        add_writeback(2, 6, 32'h0000_0001);
        add_writeback(2, 7, 32'h0000_0000);
        add_writeback(2, 8, 32'h0000_001b);
        add_writeback(2, 9, 32'h3fff_fffe);
        add_writeback(2, 10, 32'hffff_fffe);
        add_writeback(2, 11, 32'h0000_001b);
        add_writeback(2, 12, 32'h0000_0018);
        add_writeback(2, 13, 32'h0000_0050);
        add_writeback(2, 14, 32'hffff_fffd);
        add_writeback(2, 15, 32'h0000_00af);
        add_writeback(2, 16, 32'h0000_0001);
        add_writeback(3, 17, 32'h0000_000a);
        add_writeback(3, 18, 32'h0000_0058);
        add_writeback(4, 19, 32'h1234_5000);
        add_writeback(4, 24, 32'h0000_1064);
        add_writeback(4, 25, 32'h1234_5678);
        add_writeback(4, 26, 32'h0000_1064);
    endtask

    // ======================================================================
    // reporting
    // ======================================================================

    function automatic string test_name(int t);
        case (t)
            1:       return "reset and idle";
            2:       return "dependent ALU chain";
            3:       return "branches and JAL";
            4:       return "upper immediates and x0";
            default: return "halt on EBREAK";
        endcase
    endfunction

    task automatic report_mismatch(int test, string name, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        errors++;
        test_errors[test]++;
    endtask

    task automatic report_failure(int test, string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
        test_errors[test]++;
    endtask

    task automatic report_test(int test);
        if (test_errors[test] == 0) begin
            $display("test %0d %s: ok", test, test_name(test));
        end else begin
            $display("test %0d %s: FAILED with %0d errors", test, test_name(test),
                     test_errors[test]);
        end
    endtask

    initial begin
        int waited;
        int n;
        rst         = 1'b1;
        start       = 1'b0;
        prog_len    = 0;
        checks      = 0;
        errors      = 0;
        timed_out   = 1'b0;
        test_errors = new[6];
        load_program();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // the core must sit idle until start.
        repeat (3) @(negedge clk);
        checks += 5;
        if (wb_valid !== 1'b0) report_mismatch(1, "wb_valid", 32'(wb_valid), 32'd0);
        if (halted !== 1'b0) report_mismatch(1, "halted", 32'(halted), 32'd0);
        if (imem_addr !== 32'd0) report_mismatch(1, "imem_addr", imem_addr, 32'd0);
        if (cycle_count !== 32'd0) report_mismatch(1, "cycle_count", cycle_count, 32'd0);
        if (retired_count !== 32'd0) report_mismatch(1, "retired_count", retired_count, 32'd0);
        report_test(1);

        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        n = exp_rd.size();
        for (int i = 0; i < n && !timed_out; i++) begin
            waited = 0;
            @(negedge clk);
            while (!wb_valid && waited < wb_timeout) begin
                @(negedge clk);
                waited++;
            end
            checks += 2;
            if (!wb_valid) begin
                report_failure(exp_test[i], $sformatf("no register write for entry %0d", i));
                timed_out = 1'b1;
            end else begin
                if (wb_rd !== exp_rd[i]) begin
                    report_mismatch(exp_test[i], "wb_rd", 32'(wb_rd), 32'(exp_rd[i]));
                end
                if (wb_data !== exp_data[i]) begin
                    report_mismatch(exp_test[i], "wb_data", wb_data, exp_data[i]);
                end
            end
            if (i == n - 1 || exp_test[i + 1] != exp_test[i]) report_test(exp_test[i]);
        end

        // no write may follow the last expected one while the core drains.
        waited = 0;
        checks++;
        while (!halted && waited < halt_timeout) begin
            @(negedge clk);
            waited++;
            if (wb_valid) report_failure(5, $sformatf("stray write to x%0d", wb_rd));
        end
        checks += 3;
        if (!halted) begin
            report_failure(5, "halted did not rise after the EBREAK");
        end else begin
            if (retired_count !== exp_retired) begin
                report_mismatch(5, "retired_count", retired_count, exp_retired);
            end
            if (cycle_count !== exp_cycles) begin
                report_mismatch(5, "cycle_count", cycle_count, exp_cycles);
            end
        end
        for (int c = 0; c < quiet_cycles; c++) begin
            @(negedge clk);
            checks += 2;
            if (wb_valid) report_failure(5, $sformatf("write to x%0d after halt", wb_rd));
            if (halted !== 1'b1) report_mismatch(5, "halted", 32'(halted), 32'd1);
        end
        if (cycle_count !== exp_cycles) begin
            report_mismatch(5, "cycle_count", cycle_count, exp_cycles);
        end
        report_test(5);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* rv32i_core_top.f */
hdl/rv32i_pkg.sv
hdl/pipeline_pkg.sv
hdl/pipe_ctrl.sv
hdl/perf_counter.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/stage_regs.sv
hdl/execute_stage.sv
hdl/rv32i_core_top.sv
verif/tb_clock.sv
verif/core_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := core_tb
FILELIST  := rv32i_core_top.f

BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
